//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cu_cache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_clk_gen.sv
// -------------------------------------------------------------------------
// Testbench clock and reset source
// Free-running clock, synchronous reset held for a fixed cycle count
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a rising edge so the DUT sees a clean synchronous reset
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- bench/tb_cu_cache.sv
// -------------------------------------------------------------------------
// Command unit testbench
// Directed tests with a word-addressed memory model, an in-order
// response scoreboard and a memory command checker
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_cu_cache;

  import cu_cache_pkg::*;

  localparam int fifo_depth  = 32;
  localparam int prog_thresh = 16;
  localparam int wait_limit  = 3000;

  logic                 ap_clk;
  logic                 areset_m_axi;
  logic                 req_valid_i;
  mem_cmd_e             req_cmd_i;
  logic [cu_tag_w-1:0]  req_tag_i;
  logic [cu_addr_w-1:0] req_addr_i;
  logic [cu_data_w-1:0] req_wdata_i;
  logic [cu_strb_w-1:0] req_wstrb_i;
  logic                 req_full_o;
  logic                 req_prog_full_o;
  logic                 resp_pop_i;
  logic                 resp_valid_o;
  mem_cmd_e             resp_cmd_o;
  logic [cu_tag_w-1:0]  resp_tag_o;
  logic [cu_data_w-1:0] resp_rdata_o;
  logic                 mem_valid_o;
  logic [cu_addr_w-1:0] mem_addr_o;
  logic [cu_data_w-1:0] mem_wdata_o;
  logic [cu_strb_w-1:0] mem_wstrb_o;
  logic [cu_data_w-1:0] mem_rdata_i;
  logic                 mem_rvalid_i;
  logic                 mem_ready_i;
  logic                 done_o;

  // Memory seen by the DUT, and the prediction kept in request order
  logic [cu_data_w-1:0] mem_model [256];
  logic [cu_data_w-1:0] ref_mem [256];

  // Expected memory commands
  logic [cu_addr_w-1:0] exp_addr_q [$];
  logic [cu_data_w-1:0] exp_wdata_q [$];
  logic [cu_strb_w-1:0] exp_wstrb_q [$];
  // Expected responses
  mem_cmd_e             exp_cmd_q [$];
  logic [cu_tag_w-1:0]  exp_tag_q [$];
  logic [cu_data_w-1:0] exp_rdata_q [$];

  int                   errors;
  int                   strobe_count;
  int                   resp_count;
  // Separate streams for request traffic and read latency
  logic [31:0]          lcg_state;
  logic [31:0]          delay_lcg_state;

  tb_clk_gen #(.HALF_PERIOD(5), .RESET_CYCLES(8)) clk_gen_i (
    .clk_o(ap_clk),
    .rst_o(areset_m_axi)
  );

  cu_cache #(
    .FIFO_DEPTH (fifo_depth),
    .PROG_THRESH(prog_thresh)
  ) dut_i (
    .ap_clk         (ap_clk),
    .areset_m_axi   (areset_m_axi),
    .req_valid_i    (req_valid_i),
    .req_cmd_i      (req_cmd_i),
    .req_tag_i      (req_tag_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .req_wstrb_i    (req_wstrb_i),
    .req_full_o     (req_full_o),
    .req_prog_full_o(req_prog_full_o),
    .resp_pop_i     (resp_pop_i),
    .resp_valid_o   (resp_valid_o),
    .resp_cmd_o     (resp_cmd_o),
    .resp_tag_o     (resp_tag_o),
    .resp_rdata_o   (resp_rdata_o),
    .mem_valid_o    (mem_valid_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_wstrb_o    (mem_wstrb_o),
    .mem_rdata_i    (mem_rdata_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_ready_i    (mem_ready_i),
    .done_o         (done_o)
  );

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // Initial memory contents, every index gives a distinct word
  function automatic logic [31:0] fill_word(input int idx);
    return 32'h5a00_0000 ^ (32'(idx) * 32'h0001_0203);
  endfunction

  // Byte lanes with a strobe bit take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < cu_strb_w; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("ERROR: timed out waiting for %s at %0t", what, $time);
    $display("Errors: %0d, responses checked: %0d, memory strobes: %0d",
             errors + 1, resp_count, strobe_count);
    $display("Simulation FAILED");
    $finish;
  endtask

  // Idle pipeline and every expected response seen
  task automatic wait_done(input string what);
    int cycles;
    cycles = 0;
    while (!(done_o && exp_cmd_q.size() == 0)) begin
      @(posedge ap_clk);
      cycles++;
      if (cycles > wait_limit) begin
        fail_timeout(what);
      end
    end
  endtask

  task automatic wait_strobes(input int target, input string what);
    int cycles;
    cycles = 0;
    while (strobe_count < target) begin
      @(posedge ap_clk);
      cycles++;
      if (cycles > wait_limit) begin
        fail_timeout(what);
      end
    end
  endtask

  // Queue the expectations, then a one-cycle request strobe
  task automatic send_req(input mem_cmd_e cmd, input logic [7:0] tag,
                          input logic [7:0] word, input logic [31:0] wdata,
                          input logic [3:0] wstrb);
    logic [31:0] addr;
    addr = {22'd0, word, 2'b00};
    exp_addr_q.push_back(addr);
    exp_wdata_q.push_back(wdata);
    exp_cmd_q.push_back(cmd);
    exp_tag_q.push_back(tag);
    if (cmd == CMD_MEM_WRITE) begin
      exp_wstrb_q.push_back(wstrb);
      exp_rdata_q.push_back(32'h0);
      ref_mem[word] = merge_bytes(ref_mem[word], wdata, wstrb);
    end else begin
      exp_wstrb_q.push_back(4'h0);
      exp_rdata_q.push_back(ref_mem[word]);
    end
    @(posedge ap_clk);
    req_valid_i <= 1'b1;
    req_cmd_i   <= cmd;
    req_tag_i   <= tag;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    req_wstrb_i <= wstrb;
    @(posedge ap_clk);
    req_valid_i <= 1'b0;
  endtask

  // Mixed traffic over 16 words so reads hit earlier writes
  task automatic send_random(input logic [7:0] tag_base, input int count);
    logic [31:0] r;
    logic [31:0] wd;
    mem_cmd_e    cmd;
    logic [3:0]  strb;
    for (int i = 0; i < count; i++) begin
      r    = lcg_next(lcg_state);
      wd   = lcg_next(lcg_state);
      cmd  = r[31] ? CMD_MEM_WRITE : CMD_MEM_READ;
      // A write needs at least one lane, the memory port tells reads by strobe
      strb = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
      send_req(cmd, tag_base + 8'(i), {4'h3, r[19:16]}, wd, strb);
    end
  endtask

  // -------------------------------------------------------------------------
  // Memory model and command checker
  // -------------------------------------------------------------------------
  initial begin : memory_model
    logic [7:0] idx;
    int         delay;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    for (int i = 0; i < 256; i++) begin
      mem_model[i] = fill_word(i);
    end
    forever begin
      @(posedge ap_clk);
      if (!areset_m_axi && mem_valid_o) begin
        strobe_count++;
        if (exp_addr_q.size() == 0) begin
          errors++;
          $display("ERROR: memory strobe with no request pending at %0t", $time);
        end else begin
          check_value("mem_addr_o", mem_addr_o, exp_addr_q.pop_front());
          check_value("mem_wdata_o", mem_wdata_o, exp_wdata_q.pop_front());
          check_value("mem_wstrb_o", 32'(mem_wstrb_o), 32'(exp_wstrb_q.pop_front()));
        end
        idx = mem_addr_o[9:2];
        if (mem_wstrb_o != 4'h0) begin
          mem_model[idx] = merge_bytes(mem_model[idx], mem_wdata_o, mem_wstrb_o);
        end else begin
          // Read latency of 1 to 4 cycles
          delay = 1 + int'((lcg_next(delay_lcg_state) >> 16) % 4);
          repeat (delay) @(posedge ap_clk);
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= mem_model[idx];
          @(posedge ap_clk);
          mem_rvalid_i <= 1'b0;
        end
      end
    end
  end

  // In-order response scoreboard
  initial begin : resp_monitor
    forever begin
      @(posedge ap_clk);
      if (!areset_m_axi && resp_valid_o) begin
        resp_count++;
        if (exp_cmd_q.size() == 0) begin
          errors++;
          $display("ERROR: response with no request outstanding at %0t", $time);
        end else begin
          check_value("resp_cmd_o", 32'(resp_cmd_o), 32'(exp_cmd_q.pop_front()));
          check_value("resp_tag_o", 32'(resp_tag_o), 32'(exp_tag_q.pop_front()));
          check_value("resp_rdata_o", resp_rdata_o, exp_rdata_q.pop_front());
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------------
  task automatic test_after_reset();
    int cycles;
    cycles = 0;
    while (areset_m_axi !== 1'b0) begin
      @(posedge ap_clk);
      cycles++;
      if (cycles > wait_limit) begin
        fail_timeout("reset release");
      end
    end
    @(posedge ap_clk);
    check_value("mem_valid_o", 32'(mem_valid_o), 32'h0);
    check_value("resp_valid_o", 32'(resp_valid_o), 32'h0);
    check_value("req_full_o", 32'(req_full_o), 32'h0);
    wait_done("done_o after reset");
  endtask

  task automatic test_write_read();
    send_req(CMD_MEM_WRITE, 8'h10, 8'h21, 32'hdead_beef, 4'b0101);
    send_req(CMD_MEM_READ, 8'h11, 8'h21, 32'h1111_2222, 4'hf);
    send_req(CMD_MEM_WRITE, 8'h12, 8'h22, 32'hcafe_f00d, 4'hf);
    send_req(CMD_MEM_READ, 8'h13, 8'h22, 32'h0, 4'h0);
    wait_done("write and read back");
  endtask

  task automatic test_ordering();
    send_random(8'h40, 12);
    wait_done("ordering burst");
  endtask

  // Responses pile up until prog_full stops new memory commands
  task automatic test_backpressure();
    int start_strobes;
    int start_resps;
    @(posedge ap_clk);
    resp_pop_i    <= 1'b0;
    start_strobes  = strobe_count;
    start_resps    = resp_count;
    send_random(8'h80, prog_thresh + 4);
    wait_strobes(start_strobes + prog_thresh, "strobes up to prog_full");
    repeat (40) @(posedge ap_clk);
    check_value("mem strobes while stalled", 32'(strobe_count - start_strobes),
                32'(prog_thresh));
    check_value("responses while stalled", 32'(resp_count - start_resps), 32'h0);
    resp_pop_i <= 1'b1;
    wait_done("drain after back-pressure");
  endtask

  // Requests collect in the request FIFO up to its threshold
  task automatic test_mem_not_ready();
    int start_strobes;
    @(posedge ap_clk);
    mem_ready_i   <= 1'b0;
    start_strobes  = strobe_count;
    send_random(8'hc0, prog_thresh);
    repeat (30) @(posedge ap_clk);
    check_value("mem strobes while not ready", 32'(strobe_count - start_strobes), 32'h0);
    check_value("done_o while not ready", 32'(done_o), 32'h0);
    check_value("req_prog_full_o", 32'(req_prog_full_o), 32'h1);
    check_value("req_full_o", 32'(req_full_o), 32'h0);
    mem_ready_i <= 1'b1;
    wait_done("completion after memory ready");
    check_value("req_prog_full_o", 32'(req_prog_full_o), 32'h0);
  endtask

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------
  initial begin : main_seq
    errors          = 0;
    strobe_count    = 0;
    resp_count      = 0;
    lcg_state       = 32'h4e23;
    delay_lcg_state = 32'h4e23;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
    end
    req_valid_i = 1'b0;
    req_cmd_i   = CMD_MEM_READ;
    req_tag_i   = '0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_wstrb_i = '0;
    resp_pop_i  = 1'b1;
    mem_ready_i = 1'b1;

    test_after_reset();
    test_write_read();
    test_ordering();
    test_backpressure();
    test_mem_not_ready();

    repeat (5) @(posedge ap_clk);
    if (exp_addr_q.size() != 0 || exp_cmd_q.size() != 0) begin
      errors++;
      $display("ERROR: requests left without a memory command or response");
    end
    $display("Errors: %0d, responses checked: %0d, memory strobes: %0d",
             errors, resp_count, strobe_count);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_cu_cache

`default_nettype wire

//--- filelist.f
hdl/cu_cache_pkg.sv
hdl/cu_sync_fifo.sv
hdl/cu_cache_cmd_fsm.sv
hdl/cu_cache.sv
bench/tb_clk_gen.sv
bench/tb_cu_cache.sv

//--- hdl/cu_cache.sv
// -------------------------------------------------------------------------
// Command unit top level
// Registered request and response stages around a request FIFO, the
// command FSM and a response FIFO, plus the done flag
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cu_cache #(
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic                               ap_clk,
  input  logic                               areset_m_axi,
  // Request side
  input  logic                               req_valid_i,
  input  cu_cache_pkg::mem_cmd_e             req_cmd_i,
  input  logic [cu_cache_pkg::cu_tag_w-1:0]  req_tag_i,
  input  logic [cu_cache_pkg::cu_addr_w-1:0] req_addr_i,
  input  logic [cu_cache_pkg::cu_data_w-1:0] req_wdata_i,
  input  logic [cu_cache_pkg::cu_strb_w-1:0] req_wstrb_i,
  output logic                               req_full_o,
  output logic                               req_prog_full_o,
  // Response side
  input  logic                               resp_pop_i,
  output logic                               resp_valid_o,
  output cu_cache_pkg::mem_cmd_e             resp_cmd_o,
  output logic [cu_cache_pkg::cu_tag_w-1:0]  resp_tag_o,
  output logic [cu_cache_pkg::cu_data_w-1:0] resp_rdata_o,
  // Memory port
  output logic                               mem_valid_o,
  output logic [cu_cache_pkg::cu_addr_w-1:0] mem_addr_o,
  output logic [cu_cache_pkg::cu_data_w-1:0] mem_wdata_o,
  output logic [cu_cache_pkg::cu_strb_w-1:0] mem_wstrb_o,
  input  logic [cu_cache_pkg::cu_data_w-1:0] mem_rdata_i,
  input  logic                               mem_rvalid_i,
  input  logic                               mem_ready_i,
  output logic                               done_o
);

  import cu_cache_pkg::*;

  // Registered request inputs
  logic                 req_valid_q;
  mem_cmd_e             req_cmd_q;
  logic [cu_tag_w-1:0]  req_tag_q;
  logic [cu_addr_w-1:0] req_addr_q;
  logic [cu_data_w-1:0] req_wdata_q;
  logic [cu_strb_w-1:0] req_wstrb_q;
  logic                 resp_pop_q;

  // Request FIFO
  logic [cu_req_w-1:0]  req_din;
  logic [cu_req_w-1:0]  req_dout;
  logic                 req_head_valid;
  logic                 req_pop;
  logic                 req_full;
  logic                 req_empty;
  logic                 req_prog_full;
  logic                 head_cmd_bit;
  logic [cu_tag_w-1:0]  head_tag;
  logic [cu_addr_w-1:0] head_addr;
  logic [cu_data_w-1:0] head_wdata;
  logic [cu_strb_w-1:0] head_wstrb;

  // Response FIFO
  logic [cu_resp_w-1:0] resp_din;
  logic [cu_resp_w-1:0] resp_dout;
  logic                 resp_push;
  logic                 resp_rd_en;
  logic                 resp_fifo_valid;
  logic                 resp_empty;
  logic                 resp_prog_full;
  mem_cmd_e             fsm_resp_cmd;
  logic [cu_tag_w-1:0]  fsm_resp_tag;
  logic [cu_data_w-1:0] fsm_resp_rdata;

  logic                 fsm_idle;
  logic                 done_q;

  // -------------------------------------------------------------------------
  // Input stage
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      req_valid_q <= 1'b0;
      resp_pop_q  <= 1'b0;
    end else begin
      req_valid_q <= req_valid_i;
      resp_pop_q  <= resp_pop_i;
    end
  end

  always_ff @(posedge ap_clk) begin
    req_cmd_q   <= req_cmd_i;
    req_tag_q   <= req_tag_i;
    req_addr_q  <= req_addr_i;
    req_wdata_q <= req_wdata_i;
    req_wstrb_q <= req_wstrb_i;
  end

  // -------------------------------------------------------------------------
  // Request FIFO, first-word-fall-through
  // -------------------------------------------------------------------------
  assign req_din = {req_cmd_q, req_tag_q, req_addr_q, req_wdata_q, req_wstrb_q};
  assign {head_cmd_bit, head_tag, head_addr, head_wdata, head_wstrb} = req_dout;

  cu_sync_fifo #(
    .WIDTH      (cu_req_w),
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH),
    .FWFT       (1'b1)
  ) req_fifo_i (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .wr_en_i     (req_valid_q),
    .din_i       (req_din),
    .rd_en_i     (req_pop),
    .dout_o      (req_dout),
    .valid_o     (req_head_valid),
    .full_o      (req_full),
    .empty_o     (req_empty),
    .prog_full_o (req_prog_full)
  );

  // -------------------------------------------------------------------------
  // Command FSM
  // -------------------------------------------------------------------------
  cu_cache_cmd_fsm cmd_fsm_i (
    .ap_clk          (ap_clk),
    .areset_m_axi    (areset_m_axi),
    .head_valid_i    (req_head_valid),
    .head_cmd_i      (mem_cmd_e'(head_cmd_bit)),
    .head_tag_i      (head_tag),
    .head_addr_i     (head_addr),
    .head_wdata_i    (head_wdata),
    .head_wstrb_i    (head_wstrb),
    .resp_prog_full_i(resp_prog_full),
    .mem_ready_i     (mem_ready_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_valid_o     (mem_valid_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_wstrb_o     (mem_wstrb_o),
    .req_pop_o       (req_pop),
    .resp_push_o     (resp_push),
    .resp_cmd_o      (fsm_resp_cmd),
    .resp_tag_o      (fsm_resp_tag),
    .resp_rdata_o    (fsm_resp_rdata),
    .idle_o          (fsm_idle)
  );

  // -------------------------------------------------------------------------
  // Response FIFO, standard read
  // -------------------------------------------------------------------------
  assign resp_din   = {fsm_resp_cmd, fsm_resp_tag, fsm_resp_rdata};
  // Level pop from outside, held off when empty
  assign resp_rd_en = resp_pop_q & ~resp_empty;

  cu_sync_fifo #(
    .WIDTH      (cu_resp_w),
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH),
    .FWFT       (1'b0)
  ) resp_fifo_i (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .wr_en_i     (resp_push),
    .din_i       (resp_din),
    .rd_en_i     (resp_rd_en),
    .dout_o      (resp_dout),
    .valid_o     (resp_fifo_valid),
    // prog_full stops the FSM well before this
    .full_o      (),
    .empty_o     (resp_empty),
    .prog_full_o (resp_prog_full)
  );

  // -------------------------------------------------------------------------
  // Output stage and done flag
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      resp_valid_o    <= 1'b0;
      req_full_o      <= 1'b0;
      req_prog_full_o <= 1'b0;
      done_q          <= 1'b0;
      done_o          <= 1'b0;
    end else begin
      resp_valid_o    <= resp_fifo_valid;
      req_full_o      <= req_full;
      req_prog_full_o <= req_prog_full;
      // Nothing queued, nothing in flight, memory idle
      done_q          <= req_empty & resp_empty & fsm_idle & mem_ready_i;
      done_o          <= done_q;
    end
  end

  always_ff @(posedge ap_clk) begin
    resp_cmd_o   <= mem_cmd_e'(resp_dout[cu_resp_w-1]);
    resp_tag_o   <= resp_dout[cu_data_w +: cu_tag_w];
    resp_rdata_o <= resp_dout[cu_data_w-1:0];
  end

endmodule : cu_cache

`default_nettype wire

//--- hdl/cu_cache_cmd_fsm.sv
// -------------------------------------------------------------------------
// Command FSM for the command unit
// Takes one request at a time, strobes it on the memory port, waits for
// read data or the write tail, then pops the request and pushes a response
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cu_cache_cmd_fsm (
  input  logic                               ap_clk,
  input  logic                               areset_m_axi,
  // Request FIFO head
  input  logic                               head_valid_i,
  input  cu_cache_pkg::mem_cmd_e             head_cmd_i,
  input  logic [cu_cache_pkg::cu_tag_w-1:0]  head_tag_i,
  input  logic [cu_cache_pkg::cu_addr_w-1:0] head_addr_i,
  input  logic [cu_cache_pkg::cu_data_w-1:0] head_wdata_i,
  input  logic [cu_cache_pkg::cu_strb_w-1:0] head_wstrb_i,
  input  logic                               resp_prog_full_i,
  // Memory port
  input  logic                               mem_ready_i,
  input  logic                               mem_rvalid_i,
  input  logic [cu_cache_pkg::cu_data_w-1:0] mem_rdata_i,
  output logic                               mem_valid_o,
  output logic [cu_cache_pkg::cu_addr_w-1:0] mem_addr_o,
  output logic [cu_cache_pkg::cu_data_w-1:0] mem_wdata_o,
  output logic [cu_cache_pkg::cu_strb_w-1:0] mem_wstrb_o,
  // FIFO sequencing
  output logic                               req_pop_o,
  output logic                               resp_push_o,
  // Response word
  output cu_cache_pkg::mem_cmd_e             resp_cmd_o,
  output logic [cu_cache_pkg::cu_tag_w-1:0]  resp_tag_o,
  output logic [cu_cache_pkg::cu_data_w-1:0] resp_rdata_o,
  output logic                               idle_o
);

  import cu_cache_pkg::*;

  cu_cmd_state_e state_q;
  cu_cmd_state_e state_d;
  logic          issue;
  logic          issue_write;

  // Start only with a head word, a ready memory and room for the response
  assign issue       = (state_q == CMD_READY) & head_valid_i & mem_ready_i
                       & ~resp_prog_full_i;
  assign issue_write = issue & (head_cmd_i == CMD_MEM_WRITE);

  assign idle_o = (state_q == CMD_READY);

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      CMD_RESET: begin
        state_d = CMD_READY;
      end
      CMD_READY: begin
        if (issue_write) begin
          state_d = CMD_WRITE_TRANS;
        end else if (issue) begin
          state_d = CMD_READ_TRANS;
        end
      end
      // Strobe is out this cycle
      CMD_READ_TRANS: begin
        state_d = CMD_READ;
      end
      // Hold until read data returns
      CMD_READ: begin
        if (mem_rvalid_i) begin
          state_d = CMD_POP_TRANS;
        end
      end
      CMD_WRITE_TRANS: begin
        state_d = CMD_WRITE;
      end
      // Fixed three-cycle write tail
      CMD_WRITE: begin
        state_d = CMD_WRITE_POST;
      end
      CMD_WRITE_POST: begin
        state_d = CMD_WRITE_POST_2;
      end
      CMD_WRITE_POST_2: begin
        state_d = CMD_POP_TRANS;
      end
      CMD_POP_TRANS: begin
        state_d = CMD_POP;
      end
      // Pop and push strobes are high here
      CMD_POP: begin
        state_d = CMD_READY;
      end
      default: begin
        state_d = CMD_RESET;
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // State and strobes
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      state_q     <= CMD_RESET;
      mem_valid_o <= 1'b0;
      req_pop_o   <= 1'b0;
      resp_push_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      mem_valid_o <= issue;
      req_pop_o   <= (state_q == CMD_POP_TRANS);
      resp_push_o <= (state_q == CMD_POP_TRANS);
    end
  end

  // Memory command and response fields, loaded at issue
  always_ff @(posedge ap_clk) begin
    if (issue) begin
      mem_addr_o  <= head_addr_i;
      mem_wdata_o <= head_wdata_i;
      // Reads carry no byte enables
      mem_wstrb_o <= head_wstrb_i & {cu_strb_w{head_cmd_i == CMD_MEM_WRITE}};
      resp_cmd_o  <= head_cmd_i;
      resp_tag_o  <= head_tag_i;
    end
  end

  // Read data capture, zero for a write response
  always_ff @(posedge ap_clk) begin
    if (mem_rvalid_i) begin
      resp_rdata_o <= mem_rdata_i;
    end else if (issue_write) begin
      resp_rdata_o <= '0;
    end
  end

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------
  a_mem_valid_pulse: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    mem_valid_o |=> !mem_valid_o);

  // Request leaves one FIFO as its response enters the other, head still there
  a_pop_push_pair: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    (req_pop_o || resp_push_o) |-> (req_pop_o && resp_push_o && head_valid_i));

  // Read data only returns while a read waits for it
  a_rvalid_in_read: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    mem_rvalid_i |-> (state_q == CMD_READ));

endmodule : cu_cache_cmd_fsm

`default_nettype wire

//--- hdl/cu_cache_pkg.sv
// -------------------------------------------------------------------------
// Command unit shared definitions
// Bus widths, memory command encoding, command FSM states and the
// packed widths of the request and response FIFO words
// -------------------------------------------------------------------------

`default_nettype none

package cu_cache_pkg;

  // Datapath widths
  localparam int cu_addr_w = 32;
  localparam int cu_data_w = 32;
  localparam int cu_strb_w = cu_data_w / 8;
  localparam int cu_tag_w  = 8;
  localparam int cu_cmd_w  = 1;

  // Request word is cmd, tag, addr, wdata, wstrb from MSB down
  localparam int cu_req_w  = cu_cmd_w + cu_tag_w + cu_addr_w + cu_data_w + cu_strb_w;
  // Response word is cmd, tag, rdata from MSB down
  localparam int cu_resp_w = cu_cmd_w + cu_tag_w + cu_data_w;

  // Memory command carried with each request
  typedef enum logic [cu_cmd_w-1:0] {
    CMD_MEM_READ  = 1'b0,
    CMD_MEM_WRITE = 1'b1
  } mem_cmd_e;

  // -------------------------------------------------------------------------
  // Command FSM states
  // -------------------------------------------------------------------------
  typedef enum logic [3:0] {
    CMD_RESET        = 4'd0,
    CMD_READY        = 4'd1,
    CMD_READ_TRANS   = 4'd2,
    CMD_READ         = 4'd3,
    CMD_WRITE_TRANS  = 4'd4,
    CMD_WRITE        = 4'd5,
    CMD_WRITE_POST   = 4'd6,
    CMD_WRITE_POST_2 = 4'd7,
    CMD_POP_TRANS    = 4'd8,
    CMD_POP          = 4'd9
  } cu_cmd_state_e;

endpackage : cu_cache_pkg

`default_nettype wire

//--- hdl/cu_sync_fifo.sv
// -------------------------------------------------------------------------
// Synchronous FIFO with registered flags and a programmable-full level
// FWFT = 1 shows the head word with valid, FWFT = 0 reads on rd_en
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cu_sync_fifo #(
  parameter int WIDTH       = 32,
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16,
  parameter bit FWFT        = 1'b0
) (
  input  logic             ap_clk,
  input  logic             areset_m_axi,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             valid_o,
  output logic             full_o,
  output logic             empty_o,
  output logic             prog_full_o
);

  localparam int ptr_w   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int count_w = $clog2(FIFO_DEPTH + 1);

  logic [WIDTH-1:0]   mem [FIFO_DEPTH];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  logic [count_w-1:0] count_q;
  logic [count_w-1:0] count_d;
  logic               wr_fire;
  logic               rd_fire;

  // Overflow and underflow attempts are dropped here
  assign wr_fire = wr_en_i & ~full_o;
  assign rd_fire = rd_en_i & ~empty_o;

  // Occupancy after this edge
  always_comb begin
    case ({wr_fire, rd_fire})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  // -------------------------------------------------------------------------
  // Pointers, occupancy and flags
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      empty_o     <= 1'b1;
      full_o      <= 1'b0;
      prog_full_o <= 1'b0;
    end else begin
      // Wrap at the last slot, depth need not be a power of two
      if (wr_fire) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q     <= count_d;
      empty_o     <= (count_d == '0);
      full_o      <= (count_d == count_w'(FIFO_DEPTH));
      prog_full_o <= (count_d >= count_w'(PROG_THRESH));
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (wr_fire) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  // -------------------------------------------------------------------------
  // Read port
  // -------------------------------------------------------------------------
  if (FWFT) begin : g_fwft
    // Head word always on the output, rd_en acts as pop
    assign dout_o  = mem[rd_ptr_q];
    assign valid_o = ~empty_o;
  end else begin : g_std
    // Word and valid one cycle after the read strobe
    always_ff @(posedge ap_clk) begin
      if (areset_m_axi) begin
        valid_o <= 1'b0;
      end else begin
        valid_o <= rd_fire;
      end
    end

    always_ff @(posedge ap_clk) begin
      if (rd_fire) begin
        dout_o <= mem[rd_ptr_q];
      end
    end
  end

  // Producer must watch full
  a_no_write_full: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    !(wr_en_i && full_o));

  // Consumer must watch empty or valid
  a_no_read_empty: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    !(rd_en_i && empty_o));

endmodule : cu_sync_fifo

`default_nettype wire
